/* verilog.f */
hw/ex_pkg.sv
hw/id_ex_reg.sv
hw/ex_stage.sv
hw/ex_mem_reg.sv
hw/ex_subsys_top.sv
testbench/ex_subsys_sva.sv
testbench/tb_ex_subsys.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_ex_subsys
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_ex_subsys.sv */
`timescale 1ns/1ps

module tb_ex_subsys;

    localparam int N_INSTR         = 38 * 6;
    localparam int MAX_STALL       = 3;
    localparam int CLK_PERIOD      = 10;
    localparam int WATCHDOG_CYCLES = N_INSTR * (2 + MAX_STALL) + 20;  // Gap and stall burst worst case

    logic                          clk_i;
    logic                          arst_n_i;
    logic                          id_valid_i;
    logic [ex_pkg::CMD_W-1:0]      id_cmd_i;
    logic [ex_pkg::XLEN-1:0]       id_pc_i;
    logic [ex_pkg::XLEN-1:0]       id_imm_i;
    logic [ex_pkg::XLEN-1:0]       id_rs1_data_i;
    logic [ex_pkg::XLEN-1:0]       id_rs2_data_i;
    logic [ex_pkg::REG_ADDR_W-1:0] id_rd_i;
    logic                          id_rd_we_i;
    logic                          mem_stall_i;
    logic                          mem_valid_o;
    logic [ex_pkg::CMD_W-1:0]      mem_cmd_o;
    logic [ex_pkg::REG_ADDR_W-1:0] mem_rd_o;
    logic                          mem_rd_we_o;
    logic [ex_pkg::XLEN-1:0]       mem_rd_data_o;
    logic [ex_pkg::XLEN-1:0]       mem_addr_o;
    logic                          mem_read_o;
    logic                          mem_write_o;
    logic [ex_pkg::XLEN-1:0]       mem_store_data_o;
    logic                          branch_o;
    logic [ex_pkg::XLEN-1:0]       branch_target_o;
    logic                          ex_fwd_we_o;
    logic [ex_pkg::REG_ADDR_W-1:0] ex_fwd_rd_o;
    logic [ex_pkg::XLEN-1:0]       ex_fwd_data_o;
    logic                          ex_is_load_o;
    logic                          flush_o;

    int          errors = 0;
    logic [31:0] lfsr = 32'h3420_544a;

    // Model of the ID/EX slot and of the EX/MEM register
    logic                   m1_valid, m1_we;
    logic [5:0]             m1_cmd;
    logic [4:0]             m1_rd;
    logic [31:0]            m1_pc, m1_imm, m1_a, m1_b;
    logic                   m2_valid, m2_we, m2_read, m2_write, m2_br;
    logic [5:0]             m2_cmd;
    logic [4:0]             m2_rd;
    logic [31:0]            m2_data, m2_addr, m2_sdata, m2_tgt;

    ex_subsys_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the instruction stream did not complete in time");
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Expected execute results for the instruction in the modeled ID/EX slot
    task automatic model_execute(output logic we, output logic [31:0] data, output logic br,
                                 output logic [31:0] tgt, output logic ld, output logic st);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        is_br;
        a     = m1_a;
        b     = m1_b;
        imm   = m1_imm;
        data  = '0;
        br    = 1'b0;
        tgt   = m1_pc + imm;
        ld    = (m1_cmd >= ex_pkg::CMD_LB) && (m1_cmd <= ex_pkg::CMD_LHU);
        st    = (m1_cmd >= ex_pkg::CMD_SB) && (m1_cmd <= ex_pkg::CMD_SW);
        is_br = (m1_cmd >= ex_pkg::CMD_BEQ) && (m1_cmd <= ex_pkg::CMD_BGEU);
        case (m1_cmd)
            ex_pkg::CMD_LUI:   data = imm;
            ex_pkg::CMD_AUIPC: data = m1_pc + imm;
            ex_pkg::CMD_JAL: begin
                data = m1_pc + 32'd4;
                br   = 1'b1;
            end
            ex_pkg::CMD_JALR: begin
                data = m1_pc + 32'd4;
                br   = 1'b1;
                tgt  = (a + imm) & ~32'd1;
            end
            ex_pkg::CMD_BEQ:   br = (a == b);
            ex_pkg::CMD_BNE:   br = (a != b);
            ex_pkg::CMD_BLT:   br = ($signed(a) < $signed(b));
            ex_pkg::CMD_BGE:   br = !($signed(a) < $signed(b));
            ex_pkg::CMD_BLTU:  br = (a < b);
            ex_pkg::CMD_BGEU:  br = !(a < b);
            ex_pkg::CMD_ADDI:  data = a + imm;
            ex_pkg::CMD_SLTI:  data = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            ex_pkg::CMD_SLTIU: data = (a < imm) ? 32'd1 : 32'd0;
            ex_pkg::CMD_XORI:  data = a ^ imm;
            ex_pkg::CMD_ORI:   data = a | imm;
            ex_pkg::CMD_ANDI:  data = a & imm;
            ex_pkg::CMD_SLLI:  data = a << imm[4:0];
            ex_pkg::CMD_SRLI:  data = a >> imm[4:0];
            ex_pkg::CMD_SRAI:  data = $unsigned($signed(a) >>> imm[4:0]);
            ex_pkg::CMD_ADD:   data = a + b;
            ex_pkg::CMD_SUB:   data = a - b;
            ex_pkg::CMD_SLL:   data = a << b[4:0];
            ex_pkg::CMD_SLT:   data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex_pkg::CMD_SLTU:  data = (a < b) ? 32'd1 : 32'd0;
            ex_pkg::CMD_XOR:   data = a ^ b;
            ex_pkg::CMD_SRL:   data = a >> b[4:0];
            ex_pkg::CMD_SRA:   data = $unsigned($signed(a) >>> b[4:0]);
            ex_pkg::CMD_OR:    data = a | b;
            ex_pkg::CMD_AND:   data = a & b;
            default: ;
        endcase
        we = m1_valid && m1_we && (m1_rd != 5'd0) && (m1_cmd != ex_pkg::CMD_NOP) && !is_br && !st;
        br = m1_valid && br;
        ld = m1_valid && ld;
        st = m1_valid && st;
    endtask

    always @(posedge clk_i or negedge arst_n_i) begin
        logic        we, br, ld, st;
        logic [31:0] data, tgt;
        if (!arst_n_i) begin
            m1_valid = 1'b0;
            m2_valid = 1'b0;
            m2_we    = 1'b0;
            m2_read  = 1'b0;
            m2_write = 1'b0;
            m2_br    = 1'b0;
        end else if (!mem_stall_i) begin
            model_execute(we, data, br, tgt, ld, st);
            m2_valid = m1_valid;
            m2_cmd   = m1_cmd;
            m2_we    = we;
            m2_rd    = m1_rd;
            m2_data  = data;
            m2_read  = ld;
            m2_write = st;
            m2_addr  = m1_a + m1_imm;
            m2_sdata = m1_b;
            m2_br    = br;
            m2_tgt   = tgt;
            m1_valid = id_valid_i && !br;  // Taken branch kills the decode slot
            m1_cmd   = id_cmd_i;
            m1_pc    = id_pc_i;
            m1_imm   = id_imm_i;
            m1_a     = id_rs1_data_i;
            m1_b     = id_rs2_data_i;
            m1_rd    = id_rd_i;
            m1_we    = id_rd_we_i;
        end
    end

    always @(negedge clk_i) begin
        logic        we, br, ld, st;
        logic [31:0] data, tgt;
        if (arst_n_i) begin
            model_execute(we, data, br, tgt, ld, st);
            check("fwd_we", 32'(we), 32'(ex_fwd_we_o));
            if (we) begin
                check("fwd_rd", 32'(m1_rd), 32'(ex_fwd_rd_o));
                if (!ld) check("fwd_data", data, ex_fwd_data_o);
            end
            check("is_load", 32'(we && ld), 32'(ex_is_load_o));
            check("flush", 32'(br), 32'(flush_o));
            check("mem_valid", 32'(m2_valid), 32'(mem_valid_o));
            check("mem_rd_we", 32'(m2_we), 32'(mem_rd_we_o));  // Bubbles carry no strobes
            check("mem_read", 32'(m2_read), 32'(mem_read_o));
            check("mem_write", 32'(m2_write), 32'(mem_write_o));
            check("branch", 32'(m2_br), 32'(branch_o));
            if (m2_valid) check("mem_cmd", 32'(m2_cmd), 32'(mem_cmd_o));
            if (m2_we) check("mem_rd", 32'(m2_rd), 32'(mem_rd_o));
            if (m2_we && !m2_read) check("mem_rd_data", m2_data, mem_rd_data_o);
            if (m2_read || m2_write) check("mem_addr", m2_addr, mem_addr_o);
            if (m2_write) check("store_data", m2_sdata, mem_store_data_o);
            if (m2_br) check("branch_target", m2_tgt, branch_target_o);
        end
    end

    initial begin
        logic [5:0]  code;
        logic [31:0] r;
        logic        stall;
        int          stalls;
        id_valid_i    = 1'b0;
        id_cmd_i      = '0;
        id_pc_i       = '0;
        id_imm_i      = '0;
        id_rs1_data_i = '0;
        id_rs2_data_i = '0;
        id_rd_i       = '0;
        id_rd_we_i    = 1'b0;
        mem_stall_i   = 1'b0;
        arst_n_i      = 1'b1;
        code          = '0;
        #1 arst_n_i = 1'b0;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;
        for (int i = 0; i < N_INSTR; i++) begin
            if (rand_bits(3) == 0) begin
                id_valid_i  <= 1'b0;
                mem_stall_i <= 1'b0;
                @(posedge clk_i);
            end
            r = rand_bits(32);
            id_cmd_i      <= code;
            id_rs1_data_i <= r;
            id_rs2_data_i <= rand_bits(1) ? r : rand_bits(32);  // Equal operands half the time
            id_imm_i      <= rand_bits(32);
            r = rand_bits(30);
            id_pc_i       <= {r[29:0], 2'b00};
            r = rand_bits(5);
            id_rd_i       <= r[4:0];
            id_rd_we_i    <= (rand_bits(2) != 0);
            id_valid_i    <= 1'b1;
            code = (code == ex_pkg::CMD_AND) ? 6'd0 : code + 6'd1;
            stalls = 0;
            do begin
                stall = (stalls < MAX_STALL) && (rand_bits(3) == 0);
                mem_stall_i <= stall;
                stalls++;
                @(posedge clk_i);
            end while (stall);
        end
        id_valid_i  <= 1'b0;
        mem_stall_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        $display("Checks complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* testbench/ex_subsys_sva.sv */
`timescale 1ns/1ps

module ex_subsys_sva (
    input logic                          clk_i,
    input logic                          arst_n_i,
    input logic                          id_valid_i,
    input logic                          mem_stall_i,
    input logic                          mem_valid_o,
    input logic [ex_pkg::CMD_W-1:0]      mem_cmd_o,
    input logic [ex_pkg::REG_ADDR_W-1:0] mem_rd_o,
    input logic                          mem_rd_we_o,
    input logic [ex_pkg::XLEN-1:0]       mem_rd_data_o,
    input logic [ex_pkg::XLEN-1:0]       mem_addr_o,
    input logic                          mem_read_o,
    input logic                          mem_write_o,
    input logic [ex_pkg::XLEN-1:0]       mem_store_data_o,
    input logic                          branch_o,
    input logic [ex_pkg::XLEN-1:0]       branch_target_o,
    input logic                          ex_fwd_we_o,
    input logic                          ex_is_load_o,
    input logic                          flush_o
);

    logic ctrl_any;

    assign ctrl_any = mem_valid_o || mem_rd_we_o || mem_read_o || mem_write_o || branch_o ||
                      ex_fwd_we_o || ex_is_load_o || flush_o;

    // Accepted instruction reaches the memory side two edges later
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (id_valid_i && !mem_stall_i && !flush_o) ##1 !mem_stall_i |=> mem_valid_o)
        else $error("Accepted instruction did not reach mem_valid_o after two cycles");

    // A flushed decode slot never shows up as valid
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (flush_o && !mem_stall_i) ##1 !mem_stall_i |=> !mem_valid_o)
        else $error("Instruction behind a taken branch reached the memory side");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_stall_i |=> $stable(mem_valid_o) && $stable(mem_rd_data_o) && $stable(mem_addr_o)
                        && $stable(mem_read_o) && $stable(mem_write_o) && $stable(branch_o)
                        && $stable(mem_cmd_o) && $stable(mem_rd_o) && $stable(mem_rd_we_o)
                        && $stable(mem_store_data_o) && $stable(branch_target_o))
        else $error("Memory side outputs changed during a stall");

    assert property (@(posedge clk_i) (!arst_n_i || $rose(arst_n_i)) |-> !ctrl_any)
        else $error("Control output high during or right after reset");

endmodule

bind ex_subsys_top ex_subsys_sva i_sva (.*);

/* hw/ex_subsys_top.sv */
`timescale 1ns/1ps

module ex_subsys_top (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          id_valid_i,
    input  logic [ex_pkg::CMD_W-1:0]      id_cmd_i,
    input  logic [ex_pkg::XLEN-1:0]       id_pc_i,
    input  logic [ex_pkg::XLEN-1:0]       id_imm_i,
    input  logic [ex_pkg::XLEN-1:0]       id_rs1_data_i,
    input  logic [ex_pkg::XLEN-1:0]       id_rs2_data_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] id_rd_i,
    input  logic                          id_rd_we_i,
    input  logic                          mem_stall_i,
    output logic                          mem_valid_o,
    output logic [ex_pkg::CMD_W-1:0]      mem_cmd_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] mem_rd_o,
    output logic                          mem_rd_we_o,
    output logic [ex_pkg::XLEN-1:0]       mem_rd_data_o,
    output logic [ex_pkg::XLEN-1:0]       mem_addr_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output logic [ex_pkg::XLEN-1:0]       mem_store_data_o,
    output logic                          branch_o,
    output logic [ex_pkg::XLEN-1:0]       branch_target_o,
    output logic                          ex_fwd_we_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] ex_fwd_rd_o,
    output logic [ex_pkg::XLEN-1:0]       ex_fwd_data_o,
    output logic                          ex_is_load_o,
    output logic                          flush_o
);

    logic                          ex_valid;
    logic [ex_pkg::CMD_W-1:0]      ex_cmd;
    logic [ex_pkg::XLEN-1:0]       ex_pc;
    logic [ex_pkg::XLEN-1:0]       ex_imm;
    logic [ex_pkg::XLEN-1:0]       ex_rs1;
    logic [ex_pkg::XLEN-1:0]       ex_rs2;
    logic [ex_pkg::REG_ADDR_W-1:0] ex_rd;
    logic                          ex_rd_we;

    logic [ex_pkg::REG_ADDR_W-1:0] res_rd;
    logic                          res_rd_we;
    logic [ex_pkg::XLEN-1:0]       res_rd_data;
    logic [ex_pkg::XLEN-1:0]       res_target;
    logic [ex_pkg::XLEN-1:0]       res_addr;
    logic                          res_read;
    logic                          res_write;
    logic [ex_pkg::XLEN-1:0]       res_store_data;
    logic [ex_pkg::CMD_W-1:0]      res_cmd;
    logic                          flush;  // Taken branch or jump in execute

    assign flush_o = flush;

    id_ex_reg i_id_ex (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .stall_i    (mem_stall_i),
        .flush_i    (flush),
        .valid_i    (id_valid_i),
        .cmd_i      (id_cmd_i),
        .pc_i       (id_pc_i),
        .imm_i      (id_imm_i),
        .rs1_data_i (id_rs1_data_i),
        .rs2_data_i (id_rs2_data_i),
        .rd_i       (id_rd_i),
        .rd_we_i    (id_rd_we_i),
        .valid_o    (ex_valid),
        .cmd_o      (ex_cmd),
        .pc_o       (ex_pc),
        .imm_o      (ex_imm),
        .rs1_data_o (ex_rs1),
        .rs2_data_o (ex_rs2),
        .rd_o       (ex_rd),
        .rd_we_o    (ex_rd_we)
    );

    ex_stage i_ex (
        .valid_i         (ex_valid),
        .cmd_i           (ex_cmd),
        .pc_i            (ex_pc),
        .imm_i           (ex_imm),
        .rs1_data_i      (ex_rs1),
        .rs2_data_i      (ex_rs2),
        .rd_i            (ex_rd),
        .rd_we_i         (ex_rd_we),
        .rd_o            (res_rd),
        .rd_we_o         (res_rd_we),
        .rd_data_o       (res_rd_data),
        .branch_o        (flush),
        .branch_target_o (res_target),
        .mem_addr_o      (res_addr),
        .mem_read_o      (res_read),
        .mem_write_o     (res_write),
        .store_data_o    (res_store_data),
        .cmd_o           (res_cmd),
        .fwd_we_o        (ex_fwd_we_o),
        .fwd_rd_o        (ex_fwd_rd_o),
        .fwd_data_o      (ex_fwd_data_o),
        .is_load_o       (ex_is_load_o)
    );

    ex_mem_reg i_ex_mem (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .stall_i      (mem_stall_i),
        .valid_i      (ex_valid),
        .cmd_i        (res_cmd),
        .rd_i         (res_rd),
        .rd_we_i      (res_rd_we),
        .rd_data_i    (res_rd_data),
        .addr_i       (res_addr),
        .read_i       (res_read),
        .write_i      (res_write),
        .store_data_i (res_store_data),
        .branch_i     (flush),
        .target_i     (res_target),
        .valid_o      (mem_valid_o),
        .cmd_o        (mem_cmd_o),
        .rd_o         (mem_rd_o),
        .rd_we_o      (mem_rd_we_o),
        .rd_data_o    (mem_rd_data_o),
        .addr_o       (mem_addr_o),
        .read_o       (mem_read_o),
        .write_o      (mem_write_o),
        .store_data_o (mem_store_data_o),
        .branch_o     (branch_o),
        .target_o     (branch_target_o)
    );

endmodule

/* hw/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          stall_i,
    input  logic                          valid_i,
    input  logic [ex_pkg::CMD_W-1:0]      cmd_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                          rd_we_i,
    input  logic [ex_pkg::XLEN-1:0]       rd_data_i,
    input  logic [ex_pkg::XLEN-1:0]       addr_i,
    input  logic                          read_i,
    input  logic                          write_i,
    input  logic [ex_pkg::XLEN-1:0]       store_data_i,
    input  logic                          branch_i,
    input  logic [ex_pkg::XLEN-1:0]       target_i,
    output logic                          valid_o,
    output logic [ex_pkg::CMD_W-1:0]      cmd_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                          rd_we_o,
    output logic [ex_pkg::XLEN-1:0]       rd_data_o,
    output logic [ex_pkg::XLEN-1:0]       addr_o,
    output logic                          read_o,
    output logic                          write_o,
    output logic [ex_pkg::XLEN-1:0]       store_data_o,
    output logic                          branch_o,
    output logic [ex_pkg::XLEN-1:0]       target_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin  // Comes out of reset as a bubble
            valid_o  <= 1'b0;
            cmd_o    <= ex_pkg::CMD_NOP;
            rd_we_o  <= 1'b0;
            read_o   <= 1'b0;
            write_o  <= 1'b0;
            branch_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o  <= valid_i;
            cmd_o    <= cmd_i;
            rd_we_o  <= rd_we_i;
            read_o   <= read_i;
            write_o  <= write_i;
            branch_o <= branch_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            rd_o         <= rd_i;
            rd_data_o    <= rd_data_i;
            addr_o       <= addr_i;
            store_data_o <= store_data_i;
            target_o     <= target_i;
        end
    end

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic                          valid_i,
    input  logic [ex_pkg::CMD_W-1:0]      cmd_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       imm_i,
    input  logic [ex_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [ex_pkg::XLEN-1:0]       rs2_data_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                          rd_we_i,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                          rd_we_o,
    output logic [ex_pkg::XLEN-1:0]       rd_data_o,
    output logic                          branch_o,
    output logic [ex_pkg::XLEN-1:0]       branch_target_o,
    output logic [ex_pkg::XLEN-1:0]       mem_addr_o,
    output logic                          mem_read_o,
    output logic                          mem_write_o,
    output logic [ex_pkg::XLEN-1:0]       store_data_o,
    output logic [ex_pkg::CMD_W-1:0]      cmd_o,
    output logic                          fwd_we_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] fwd_rd_o,
    output logic [ex_pkg::XLEN-1:0]       fwd_data_o,
    output logic                          is_load_o
);

    logic [ex_pkg::XLEN-1:0]    result;
    logic                       writes;     // Command class has a destination register
    logic                       taken;
    logic [ex_pkg::XLEN-1:0]    target;
    logic [ex_pkg::XLEN-1:0]    eff_addr;
    logic [ex_pkg::XLEN-1:0]    pc_rel;
    logic [ex_pkg::XLEN-1:0]    link;
    logic [ex_pkg::SHAMT_W-1:0] shamt_imm;
    logic [ex_pkg::SHAMT_W-1:0] shamt_reg;
    logic                       is_load;
    logic                       is_store;

    assign eff_addr  = rs1_data_i + imm_i;
    assign pc_rel    = pc_i + imm_i;
    assign link      = pc_i + ex_pkg::LINK_OFFSET;
    assign shamt_imm = imm_i[ex_pkg::SHAMT_W-1:0];
    assign shamt_reg = rs2_data_i[ex_pkg::SHAMT_W-1:0];

    assign is_load  = (cmd_i >= ex_pkg::CMD_LD_FIRST) && (cmd_i <= ex_pkg::CMD_LD_LAST);
    assign is_store = (cmd_i >= ex_pkg::CMD_ST_FIRST) && (cmd_i <= ex_pkg::CMD_ST_LAST);

    always_comb begin
        result = '0;
        writes = 1'b0;
        taken  = 1'b0;
        target = pc_rel;
        case (cmd_i)
            ex_pkg::CMD_LUI: begin
                result = imm_i;
                writes = 1'b1;
            end
            ex_pkg::CMD_AUIPC: begin
                result = pc_rel;
                writes = 1'b1;
            end
            ex_pkg::CMD_JAL: begin
                result = link;
                writes = 1'b1;
                taken  = 1'b1;
            end
            ex_pkg::CMD_JALR: begin
                result = link;
                writes = 1'b1;
                taken  = 1'b1;
                target = {eff_addr[ex_pkg::XLEN-1:1], 1'b0};
            end
            ex_pkg::CMD_BEQ:  taken = (rs1_data_i == rs2_data_i);
            ex_pkg::CMD_BNE:  taken = (rs1_data_i != rs2_data_i);
            ex_pkg::CMD_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            ex_pkg::CMD_BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            ex_pkg::CMD_BLTU: taken = (rs1_data_i < rs2_data_i);
            ex_pkg::CMD_BGEU: taken = (rs1_data_i >= rs2_data_i);
            ex_pkg::CMD_LB, ex_pkg::CMD_LH, ex_pkg::CMD_LW,
            ex_pkg::CMD_LBU, ex_pkg::CMD_LHU: begin
                writes = 1'b1;  // Data comes later from memory
            end
            ex_pkg::CMD_ADDI: begin
                result = eff_addr;
                writes = 1'b1;
            end
            ex_pkg::CMD_SLTI: begin
                result = {31'd0, $signed(rs1_data_i) < $signed(imm_i)};
                writes = 1'b1;
            end
            ex_pkg::CMD_SLTIU: begin
                result = {31'd0, rs1_data_i < imm_i};
                writes = 1'b1;
            end
            ex_pkg::CMD_XORI: begin
                result = rs1_data_i ^ imm_i;
                writes = 1'b1;
            end
            ex_pkg::CMD_ORI: begin
                result = rs1_data_i | imm_i;
                writes = 1'b1;
            end
            ex_pkg::CMD_ANDI: begin
                result = rs1_data_i & imm_i;
                writes = 1'b1;
            end
            ex_pkg::CMD_SLLI: begin
                result = rs1_data_i << shamt_imm;
                writes = 1'b1;
            end
            ex_pkg::CMD_SRLI: begin
                result = rs1_data_i >> shamt_imm;
                writes = 1'b1;
            end
            ex_pkg::CMD_SRAI: begin
                result = $unsigned($signed(rs1_data_i) >>> shamt_imm);
                writes = 1'b1;
            end
            ex_pkg::CMD_ADD: begin
                result = rs1_data_i + rs2_data_i;
                writes = 1'b1;
            end
            ex_pkg::CMD_SUB: begin
                result = rs1_data_i - rs2_data_i;
                writes = 1'b1;
            end
            ex_pkg::CMD_SLL: begin
                result = rs1_data_i << shamt_reg;
                writes = 1'b1;
            end
            ex_pkg::CMD_SLT: begin
                result = {31'd0, $signed(rs1_data_i) < $signed(rs2_data_i)};
                writes = 1'b1;
            end
            ex_pkg::CMD_SLTU: begin
                result = {31'd0, rs1_data_i < rs2_data_i};
                writes = 1'b1;
            end
            ex_pkg::CMD_XOR: begin
                result = rs1_data_i ^ rs2_data_i;
                writes = 1'b1;
            end
            ex_pkg::CMD_SRL: begin
                result = rs1_data_i >> shamt_reg;
                writes = 1'b1;
            end
            ex_pkg::CMD_SRA: begin
                result = $unsigned($signed(rs1_data_i) >>> shamt_reg);
                writes = 1'b1;
            end
            ex_pkg::CMD_OR: begin
                result = rs1_data_i | rs2_data_i;
                writes = 1'b1;
            end
            ex_pkg::CMD_AND: begin
                result = rs1_data_i & rs2_data_i;
                writes = 1'b1;
            end
            default: ;
        endcase
    end

    assign rd_we_o   = valid_i && writes && rd_we_i && (rd_i != '0);  // x0 is never written
    assign rd_o      = rd_we_o ? rd_i : '0;
    assign rd_data_o = valid_i ? result : '0;
    assign cmd_o     = valid_i ? cmd_i : ex_pkg::CMD_NOP;

    assign branch_o        = valid_i && taken;  // Also kills the instruction in decode
    assign branch_target_o = branch_o ? target : '0;

    assign mem_read_o   = valid_i && is_load;
    assign mem_write_o  = valid_i && is_store;
    assign mem_addr_o   = (mem_read_o || mem_write_o) ? eff_addr : '0;
    assign store_data_o = mem_write_o ? rs2_data_i : '0;

    assign fwd_we_o   = rd_we_o;
    assign fwd_rd_o   = rd_o;
    assign fwd_data_o = rd_we_o ? result : '0;
    assign is_load_o  = rd_we_o && is_load;  // Decode must wait, the value is not known yet

endmodule

/* hw/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic                          valid_i,
    input  logic [ex_pkg::CMD_W-1:0]      cmd_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       imm_i,
    input  logic [ex_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [ex_pkg::XLEN-1:0]       rs2_data_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                          rd_we_i,
    output logic                          valid_o,
    output logic [ex_pkg::CMD_W-1:0]      cmd_o,
    output logic [ex_pkg::XLEN-1:0]       pc_o,
    output logic [ex_pkg::XLEN-1:0]       imm_o,
    output logic [ex_pkg::XLEN-1:0]       rs1_data_o,
    output logic [ex_pkg::XLEN-1:0]       rs2_data_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                          rd_we_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            rd_we_o <= 1'b0;
            cmd_o   <= ex_pkg::CMD_NOP;
        end else if (!stall_i) begin  // A stalled branch keeps its flush asserted
            if (flush_i || !valid_i) begin  // Wrong-path or empty slot enters as a bubble
                valid_o <= 1'b0;
                rd_we_o <= 1'b0;
                cmd_o   <= ex_pkg::CMD_NOP;
            end else begin
                valid_o <= 1'b1;
                rd_we_o <= rd_we_i;
                cmd_o   <= cmd_i;
            end
        end
    end

    // Operands are only looked at while valid_o is high
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            pc_o       <= pc_i;
            imm_o      <= imm_i;
            rs1_data_o <= rs1_data_i;
            rs2_data_o <= rs2_data_i;
            rd_o       <= rd_i;
        end
    end

endmodule

/* hw/ex_pkg.sv */
package ex_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned CMD_W      = 6;
    localparam int unsigned SHAMT_W    = 5;

    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;  // Return address is the next word

    localparam logic [CMD_W-1:0] CMD_NOP   = 6'd0;
    localparam logic [CMD_W-1:0] CMD_LUI   = 6'd1;
    localparam logic [CMD_W-1:0] CMD_AUIPC = 6'd2;
    localparam logic [CMD_W-1:0] CMD_JAL   = 6'd3;
    localparam logic [CMD_W-1:0] CMD_JALR  = 6'd4;
    localparam logic [CMD_W-1:0] CMD_BEQ   = 6'd5;
    localparam logic [CMD_W-1:0] CMD_BNE   = 6'd6;
    localparam logic [CMD_W-1:0] CMD_BLT   = 6'd7;
    localparam logic [CMD_W-1:0] CMD_BGE   = 6'd8;
    localparam logic [CMD_W-1:0] CMD_BLTU  = 6'd9;
    localparam logic [CMD_W-1:0] CMD_BGEU  = 6'd10;
    localparam logic [CMD_W-1:0] CMD_LB    = 6'd11;
    localparam logic [CMD_W-1:0] CMD_LH    = 6'd12;
    localparam logic [CMD_W-1:0] CMD_LW    = 6'd13;
    localparam logic [CMD_W-1:0] CMD_LBU   = 6'd14;
    localparam logic [CMD_W-1:0] CMD_LHU   = 6'd15;
    localparam logic [CMD_W-1:0] CMD_SB    = 6'd16;
    localparam logic [CMD_W-1:0] CMD_SH    = 6'd17;
    localparam logic [CMD_W-1:0] CMD_SW    = 6'd18;
    localparam logic [CMD_W-1:0] CMD_ADDI  = 6'd19;
    localparam logic [CMD_W-1:0] CMD_SLTI  = 6'd20;
    localparam logic [CMD_W-1:0] CMD_SLTIU = 6'd21;
    localparam logic [CMD_W-1:0] CMD_XORI  = 6'd22;
    localparam logic [CMD_W-1:0] CMD_ORI   = 6'd23;
    localparam logic [CMD_W-1:0] CMD_ANDI  = 6'd24;
    localparam logic [CMD_W-1:0] CMD_SLLI  = 6'd25;
    localparam logic [CMD_W-1:0] CMD_SRLI  = 6'd26;
    localparam logic [CMD_W-1:0] CMD_SRAI  = 6'd27;
    localparam logic [CMD_W-1:0] CMD_ADD   = 6'd28;
    localparam logic [CMD_W-1:0] CMD_SUB   = 6'd29;
    localparam logic [CMD_W-1:0] CMD_SLL   = 6'd30;
    localparam logic [CMD_W-1:0] CMD_SLT   = 6'd31;
    localparam logic [CMD_W-1:0] CMD_SLTU  = 6'd32;
    localparam logic [CMD_W-1:0] CMD_XOR   = 6'd33;
    localparam logic [CMD_W-1:0] CMD_SRL   = 6'd34;
    localparam logic [CMD_W-1:0] CMD_SRA   = 6'd35;
    localparam logic [CMD_W-1:0] CMD_OR    = 6'd36;
    localparam logic [CMD_W-1:0] CMD_AND   = 6'd37;

    // Loads and stores occupy contiguous code ranges
    localparam logic [CMD_W-1:0] CMD_LD_FIRST = CMD_LB;
    localparam logic [CMD_W-1:0] CMD_LD_LAST  = CMD_LHU;
    localparam logic [CMD_W-1:0] CMD_ST_FIRST = CMD_SB;
    localparam logic [CMD_W-1:0] CMD_ST_LAST  = CMD_SW;

endpackage
